/* dv/pixel_readout_tb.sv */
// Testbench for the 8x8 readout with one host; pixels drop requests after grant; 4000-cycle limit
`timescale 1ns/1ps

module pixel_readout_tb;
    import pixel_arb_pkg::*;

    localparam int CYCLE_LIMIT = 4000;       // About 1000 cycles of reads and polling with wide margin

    logic        clk_i;
    logic        reset_i;
    logic [63:0] pix_req;                   // Requests as the DUT sees them
    logic [63:0] pix_gnt;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;

    logic [63:0] req_add;                   // Raised at the next drive point
    logic [63:0] gnt_seen;                  // Grants of the current cycle
    logic [63:0] pending;                   // Raised with the event not read yet
    logic [63:0] granted;                   // Granted since the last clear
    logic [5:0]  evt_log [$];               // Pixel index per event in read order
    logic        ctrl_on;                   // Last value written to CONTROL
    int          seed;
    int          gnt_count;
    int          ack_count;                 // Acks in the current bus cycle
    int          cycles       = 0;
    int          error_cnt    = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;

    pixel_readout_top i_dut (
        .clk_i     (clk_i),
        .reset_i   (reset_i),
        .pix_req_i (pix_req),
        .wb_i      (wb_req),
        .pix_gnt_o (pix_gnt),
        .wb_o      (wb_rsp)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    task automatic flag_error(input string msg);
        error_cnt++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    // Pixel array model drops a request at the drive point after its grant
    always @(posedge clk_i)
    begin
        #2;
        pix_req = (pix_req & ~gnt_seen) | req_add;
        req_add = '0;
    end

    // Grants and acks sampled mid-cycle where they are settled
    always @(negedge clk_i)
    begin
        gnt_seen = pix_gnt;
        if (!reset_i)
        begin
            for (int i = 0; i < 64; i++)
            begin
                if (pix_gnt[i])
                begin
                    assert (!granted[i]) else flag_error($sformatf("pixel %0d granted twice", i));
                    granted[i] = 1'b1;
                    gnt_count++;
                end
            end
            if (wb_rsp.ack)
                ack_count++;
        end
    end

    always @(posedge clk_i)
    begin
        cycles++;
        if (cycles >= CYCLE_LIMIT)
        begin
            $display("Timeout: the tests did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

    a_gnt_onehot: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(pix_gnt))
        else flag_error("pixel grant vector is not one-hot");
    a_gnt_to_req: assert property (@(posedge clk_i) disable iff (reset_i)
                                   (pix_gnt & ~pix_req) == '0)
        else flag_error("grant to a pixel without a request");
    a_gnt_off:    assert property (@(posedge clk_i) disable iff (reset_i)
                                   !ctrl_on |-> (pix_gnt == '0))
        else flag_error("grant while CONTROL enable is 0");
    a_ack_single: assert property (@(posedge clk_i) disable iff (reset_i) wb_rsp.ack |=> !wb_rsp.ack)
        else flag_error("ack longer than one cycle");
    a_ack_in_cyc: assert property (@(posedge clk_i) disable iff (reset_i)
                                   wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
        else flag_error("ack outside a strobed bus cycle");

    task automatic clear_board();
        pending   = '0;
        granted   = '0;
        gnt_count = 0;
        evt_log.delete();
    endtask

    task automatic reset_dut();
        reset_i  = 1'b1;
        pix_req  = '0;
        req_add  = '0;
        gnt_seen = '0;
        wb_req   = '0;
        ctrl_on  = 1'b0;
        clear_board();
        repeat (5) @(posedge clk_i);
        #2 reset_i = 1'b0;
        assert (pix_gnt == '0 && !wb_rsp.ack) else flag_error("grant or ack active out of reset");
    endtask

    task automatic raise_requests(input logic [63:0] mask);
        @(negedge clk_i);
        req_add = mask;                     // Picked up by the pixel model
        pending = pending | mask;
        @(posedge clk_i);
        #2;
    endtask

    // Classic cycle with the strobe held for hold cycles past the ack
    task automatic bus_access(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                              input int hold, output logic [31:0] rdat);
        ack_count  = 0;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        @(negedge clk_i);
        while (!wb_rsp.ack)
            @(negedge clk_i);
        rdat = wb_rsp.dat;
        if (we && adr == 4'h8)
            ctrl_on = wdat[0];
        repeat (hold + 1) @(posedge clk_i);
        #2;
        wb_req = '0;
        @(posedge clk_i);                   // Idle cycle between strobes
        #2;
        assert (ack_count == 1) else flag_error($sformatf("%0d acks for one strobe", ack_count));
    endtask

    task automatic read_reg(input logic [3:0] adr, output logic [31:0] rdat);
        bus_access(1'b0, adr, '0, 0, rdat);
    endtask

    task automatic check_event(input logic [31:0] d);
        logic [5:0] idx;
        idx = {d[5:3], d[2:0]};             // Row times 8 plus column
        assert (d[30:6] == '0) else flag_error($sformatf("EVENT unused bits set in %h", d));
        assert (pending[idx])
            else flag_error($sformatf("event row %0d col %0d is not pending", d[5:3], d[2:0]));
        pending[idx] = 1'b0;
        evt_log.push_back(idx);
    endtask

    task automatic drain_events(input int n);
        logic [31:0] d;
        int          got;
        got = 0;
        while (got < n)
        begin
            read_reg(4'h0, d);
            if (d[31])                      // Zero reads without the valid bit are skipped
            begin
                check_event(d);
                got++;
            end
        end
    endtask

    task automatic idle_after_reset();
        logic [31:0] d;
        reset_dut();
        read_reg(4'h4, d);
        assert (d == 32'h10) else flag_error($sformatf("STATUS after reset is %h, not 10", d));
        read_reg(4'h8, d);
        assert (d == 32'h0) else flag_error($sformatf("CONTROL after reset is %h, not 0", d));
        raise_requests(64'hFF00_0000_0000_00FF);     // Rows 0 and 7
        repeat (30) @(posedge clk_i);
        #2;
        read_reg(4'h4, d);
        assert (d == 32'h10 && gnt_count == 0)
            else flag_error($sformatf("%0d grants, STATUS %h with arbitration off", gnt_count, d));
    endtask

    task automatic random_patterns();
        logic [31:0] hi, lo, d;
        logic [63:0] mask;
        reset_dut();
        bus_access(1'b1, 4'h8, 32'd1, 0, d);
        for (int r = 0; r < 4; r++)
        begin
            hi        = $random(seed);
            lo        = $random(seed);
            mask      = {hi, lo} | 64'd1;   // Never an empty pattern
            granted   = '0;
            gnt_count = 0;
            raise_requests(mask);
            drain_events($countones(mask));
            assert (pending == '0) else flag_error($sformatf("round %0d left %h pending", r, pending));
            assert (granted == mask && gnt_count == $countones(mask))
                else flag_error($sformatf("round %0d granted %h, requested %h", r, granted, mask));
        end
    endtask

    task automatic group0_order();
        logic [31:0] d;
        reset_dut();
        raise_requests(64'h0000_0000_0F0F_0F0F);     // All 16 pixels of group 0
        bus_access(1'b1, 4'h8, 32'd1, 0, d);
        drain_events(16);
        for (int k = 0; k < 16; k++)
            assert (evt_log[k] == 6'((k / 4) * 8 + k % 4))
                else flag_error($sformatf("event %0d is pixel %0d, not row-major", k, evt_log[k]));
    endtask

    task automatic group_rotation();
        logic [31:0] d;
        reset_dut();
        raise_requests('1);
        bus_access(1'b1, 4'h8, 32'd1, 0, d);
        drain_events(64);
        for (int k = 0; k < 64; k++)
            assert ({evt_log[k][5], evt_log[k][2]} == 2'(k / 16))  // Group from row bit 2 and column bit 2
                else flag_error($sformatf("event %0d is pixel %0d, wrong group", k, evt_log[k]));
    endtask

    task automatic fifo_backpressure();
        logic [31:0] d;
        logic [63:0] mask;
        reset_dut();
        mask = '0;
        while ($countones(mask) < 20)
            mask[$unsigned($random(seed)) % 64] = 1'b1;
        raise_requests(mask);
        bus_access(1'b1, 4'h8, 32'd1, 0, d);
        d = '0;
        while (!d[5])
            read_reg(4'h4, d);              // Poll until full
        assert (d == 32'h28 && gnt_count == 8)
            else flag_error($sformatf("full STATUS %h after %0d grants", d, gnt_count));
        repeat (20) @(posedge clk_i);
        #2;
        read_reg(4'h4, d);
        assert (d == 32'h28 && gnt_count == 8)
            else flag_error($sformatf("grants went on while full, STATUS %h", d));
        drain_events(20);
        assert (pending == '0 && granted == mask && gnt_count == 20)
            else flag_error($sformatf("%0d grants, %h still pending", gnt_count, pending));
    endtask

    task automatic bus_protocol();
        logic [31:0] d;
        reset_dut();
        read_reg(4'h0, d);
        assert (d == '0) else flag_error($sformatf("EVENT read on empty FIFO gave %h", d));
        bus_access(1'b0, 4'h4, '0, 2, d);   // Strobe held two cycles past ack
        assert (d == 32'h10) else flag_error($sformatf("STATUS %h after empty EVENT read", d));
        bus_access(1'b1, 4'h8, 32'd1, 1, d);
        read_reg(4'h8, d);
        assert (d == 32'd1) else flag_error($sformatf("CONTROL reads %h after writing 1", d));
        raise_requests(64'd1 << 45);        // Row 5 and column 5
        drain_events(1);
        read_reg(4'h4, d);
        assert (d == 32'h10 && pending == '0)
            else flag_error($sformatf("STATUS %h after the single event", d));
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (error_cnt == errs_before)
            $display("test %-18s ok", name);
        else
        begin
            tests_failed++;
            $display("test %-18s failed with %0d errors", name, error_cnt - errs_before);
        end
    endtask

    initial
    begin
        int errs;
        $timeformat(-9, 0, " ns", 0);
        seed = 97;
        errs = error_cnt;
        idle_after_reset();
        report_test("idle_after_reset", errs);
        errs = error_cnt;
        random_patterns();
        report_test("random_patterns", errs);
        errs = error_cnt;
        group0_order();
        report_test("group0_order", errs);
        errs = error_cnt;
        group_rotation();
        report_test("group_rotation", errs);
        errs = error_cnt;
        fifo_backpressure();
        report_test("fifo_backpressure", errs);
        errs = error_cnt;
        bus_protocol();
        report_test("bus_protocol", errs);
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, error_cnt);
        if (error_cnt == 0 && tests_failed == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* rtl/column_arbiter.sv */
// One grant per enabled cycle in ascending column order; grant is cleared when not enabled
`timescale 1ns/1ps
`include "pixel_arb_settings.svh"

module column_arbiter (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          enable_i,     // Grant a column this cycle
    input  logic                          start_i,      // New row, clear the mask
    input  logic [`PIX_GRP_COLS-1:0]      req_i,        // Columns of the chosen row
    output logic [`PIX_GRP_COLS-1:0]      gnt_o,        // Registered one-hot grant
    output pixel_arb_pkg::grp_addr_t      yadd_o,       // Granted column
    output logic                          row_done_o    // No column left in this row
);
    import pixel_arb_pkg::*;

    logic [$clog2(`PIX_GRP_COLS):0] ptr_q;              // Columns below are masked
    grp_addr_t                      sel;
    logic                           found;

    always_comb
    begin
        sel   = '0;
        found = 1'b0;
        for (int i = `PIX_GRP_COLS - 1; i >= 0; i--)
        begin
            if (req_i[i] && (i >= int'(ptr_q)))         // Mask hides a falling request
            begin
                sel   = grp_addr_t'(i);
                found = 1'b1;
            end
        end
    end

    assign row_done_o = !found;

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            ptr_q  <= '0;
            gnt_o  <= '0;
            yadd_o <= '0;
        end
        else if (start_i)
        begin
            ptr_q <= '0;
            gnt_o <= '0;
        end
        else if (enable_i && found)
        begin
            gnt_o  <= `PIX_GRP_COLS'(1) << sel;         // Grant shows next cycle
            yadd_o <= sel;
            ptr_q  <= {1'b0, sel} + 1'b1;
        end
        else
            gnt_o <= '0;                                // One-cycle grant
    end

endmodule

/* rtl/event_fifo.sv */
// Event FIFO; a push while full is not guarded here, the arbiter stalls instead
`timescale 1ns/1ps
`include "pixel_arb_settings.svh"

module event_fifo (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic                         push_i,
    input  pixel_arb_pkg::pix_event_t    evt_i,
    input  logic                         pop_i,
    output pixel_arb_pkg::pix_event_t    evt_o,        // Head entry, valid when not empty
    output pixel_arb_pkg::fifo_cnt_t     count_o,
    output logic                         empty_o,
    output logic                         full_o
);
    import pixel_arb_pkg::*;

    localparam int AW = $clog2(`EVT_FIFO_DEPTH);

    pix_event_t        mem [`EVT_FIFO_DEPTH];
    logic [AW-1:0]     wr_ptr_q, rd_ptr_q;           // Wrap naturally

    always_ff @(posedge clk_i)
    begin
        if (push_i)
            mem[wr_ptr_q] <= evt_i;
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_o  <= '0;
        end
        else
        begin
            if (push_i)
                wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop_i)
                rd_ptr_q <= rd_ptr_q + 1'b1;
            if (push_i && !pop_i)
                count_o <= count_o + 1'b1;
            else if (pop_i && !push_i)
                count_o <= count_o - 1'b1;
        end
    end

    assign evt_o   = mem[rd_ptr_q];
    assign empty_o = (count_o == '0);
    assign full_o  = (count_o == fifo_cnt_t'(`EVT_FIFO_DEPTH));

    a_no_pop_empty: assert property (@(posedge clk_i) disable iff (reset_i)
                                     pop_i |-> !empty_o);

endmodule

/* rtl/pixel_arb_pkg.sv */
// Shared types; widths follow the settings header, square groups and a square array assumed
`include "pixel_arb_settings.svh"

package pixel_arb_pkg;

    typedef logic [$clog2(`PIX_GRP_ROWS)-1:0] grp_addr_t;                // Row or column inside a group
    typedef logic [$clog2(`PIX_GRP_ROWS*`PIX_GRPS_Y)-1:0] pix_addr_t;   // Global row or column
    typedef logic [$clog2(`PIX_GRPS_X*`PIX_GRPS_Y)-1:0] grp_sel_t;      // Group index
    typedef logic [$clog2(`EVT_FIFO_DEPTH):0] fifo_cnt_t;               // Occupancy 0 to depth

    typedef struct packed {
        pix_addr_t row;                                                  // Global row
        pix_addr_t col;                                                  // Global column
    } pix_event_t;

    typedef struct packed {
        logic        cyc;                                                // Bus cycle
        logic        stb;                                                // Strobe
        logic        we;                                                 // Write enable
        logic [3:0]  adr;                                                // Byte address
        logic [31:0] dat;                                                // Write data
    } wb_req_t;

    typedef struct packed {
        logic        ack;                                                // Single-cycle ack
        logic [31:0] dat;                                                // Read data
    } wb_rsp_t;

    typedef enum logic [1:0] {
        IDLE      = 2'b00,                                               // Waiting for enable
        ROW_GRANT = 2'b01,                                               // Row selection cycle
        COL_GRANT = 2'b10                                                // Serving the chosen row
    } l1_state_t;

endpackage

/* rtl/pixel_arb_settings.svh */
// Array geometry and FIFO depth; group sides and FIFO depth must be powers of two
`ifndef PIXEL_ARB_SETTINGS_SVH
`define PIXEL_ARB_SETTINGS_SVH

// Pixels per group side
`define PIX_GRP_ROWS 4
`define PIX_GRP_COLS 4

// Groups per array side
`define PIX_GRPS_X 2
`define PIX_GRPS_Y 2

// Event FIFO entries
`define EVT_FIFO_DEPTH 8

`endif

/* rtl/pixel_level_1.sv */
// Group arbiter for one 4x4 group; losing the enable drops a pending grant and restarts the scan
`timescale 1ns/1ps
`include "pixel_arb_settings.svh"

module pixel_level_1 (
    input  logic                                      clk_i,
    input  logic                                      reset_i,
    input  logic                                      enable_i,       // Group selected and not stalled
    input  logic [`PIX_GRP_ROWS*`PIX_GRP_COLS-1:0]    req_i,          // Index row*cols+col
    output logic [`PIX_GRP_ROWS*`PIX_GRP_COLS-1:0]    gnt_o,          // One-hot or zero
    output pixel_arb_pkg::grp_addr_t                  x_add_o,        // Local row
    output pixel_arb_pkg::grp_addr_t                  y_add_o,        // Local column
    output logic                                      gnt_valid_o,
    output logic                                      grp_req_o,      // Any request in group
    output logic                                      grp_release_o   // All pending served
);
    import pixel_arb_pkg::*;

    l1_state_t                 state_q, state_d;
    logic [`PIX_GRP_ROWS-1:0]  row_req;
    logic [`PIX_GRP_COLS-1:0]  col_req;
    logic [`PIX_GRP_ROWS-1:0]  row_gnt;
    logic [`PIX_GRP_COLS-1:0]  col_gnt;
    logic                      x_en, y_en, refresh, start, release_d;
    logic                      pass_done, row_done;

    assign grp_req_o = |req_i;

    always_comb
    begin
        for (int r = 0; r < `PIX_GRP_ROWS; r++)
            row_req[r] = |req_i[r*`PIX_GRP_COLS +: `PIX_GRP_COLS];    // Row has a request
        for (int c = 0; c < `PIX_GRP_COLS; c++)
            col_req[c] = req_i[int'(x_add_o)*`PIX_GRP_COLS + c];      // Chosen row only
    end

    always_comb
    begin
        state_d   = state_q;
        x_en      = 1'b0;
        y_en      = 1'b0;
        refresh   = 1'b0;
        start     = 1'b0;
        release_d = 1'b0;
        if (!enable_i)
        begin
            state_d = IDLE;                              // Enable lost, restart later
            refresh = 1'b1;
        end
        else
        begin
            case (state_q)
                IDLE: state_d = ROW_GRANT;
                ROW_GRANT:
                begin
                    x_en = 1'b1;
                    if (pass_done)
                    begin
                        state_d   = IDLE;                // Nothing left at all
                        release_d = 1'b1;
                        refresh   = 1'b1;
                    end
                    else
                    begin
                        state_d = COL_GRANT;             // Row latched at this edge
                        start   = 1'b1;
                    end
                end
                COL_GRANT:
                begin
                    y_en = 1'b1;
                    if (row_done)
                    begin
                        if (pass_done)
                        begin
                            state_d   = IDLE;            // Last row finished
                            release_d = 1'b1;
                            refresh   = 1'b1;
                        end
                        else
                            state_d = ROW_GRANT;
                    end
                end
                default: state_d = IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            state_q       <= IDLE;
            grp_release_o <= 1'b0;
        end
        else
        begin
            state_q       <= state_d;
            grp_release_o <= release_d;                  // Pulse one cycle after last grant
        end
    end

    always_comb
    begin
        for (int r = 0; r < `PIX_GRP_ROWS; r++)
            for (int c = 0; c < `PIX_GRP_COLS; c++)
                gnt_o[r*`PIX_GRP_COLS + c] = row_gnt[r] & col_gnt[c] & enable_i;
    end

    assign gnt_valid_o = (|col_gnt) & enable_i;          // Suppressed while stalled

    row_arbiter i_row_arb (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .enable_i    (x_en),
        .refresh_i   (refresh),
        .req_i       (row_req),
        .gnt_o       (row_gnt),
        .xadd_o      (x_add_o),
        .pass_done_o (pass_done)
    );

    column_arbiter i_col_arb (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .enable_i    (y_en),
        .start_i     (start),
        .req_i       (col_req),
        .gnt_o       (col_gnt),
        .yadd_o      (y_add_o),
        .row_done_o  (row_done)
    );

    a_gnt_onehot: assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(gnt_o));

endmodule

/* rtl/pixel_level_2.sv */
// Rotates the enable over four groups; a full FIFO stalls the active group, which rescans
`timescale 1ns/1ps
`include "pixel_arb_settings.svh"

module pixel_level_2 (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  logic                         run_i,          // Arbitration enable from host
    input  logic                         fifo_full_i,
    input  logic [63:0]                  pix_req_i,      // Index row*8+col
    output logic [63:0]                  pix_gnt_o,
    output logic                         evt_push_o,
    output pixel_arb_pkg::pix_event_t    evt_o
);
    import pixel_arb_pkg::*;

    localparam int NG  = `PIX_GRPS_X * `PIX_GRPS_Y;
    localparam int GSZ = `PIX_GRP_ROWS * `PIX_GRP_COLS;
    localparam int RW  = `PIX_GRP_COLS * `PIX_GRPS_X;    // Array row width

    logic [NG-1:0][GSZ-1:0] grp_req, grp_gnt;
    grp_addr_t [NG-1:0]     x_add, y_add;
    logic [NG-1:0]          grp_valid, grp_any, grp_rel, grp_en;
    grp_sel_t               act_q, nxt;
    logic                   act_valid_q, nxt_found;

    for (genvar g = 0; g < NG; g++)
    begin : g_grp
        for (genvar r = 0; r < `PIX_GRP_ROWS; r++)
        begin : g_row
            for (genvar c = 0; c < `PIX_GRP_COLS; c++)
            begin : g_col
                localparam int P = ((g / `PIX_GRPS_X) * `PIX_GRP_ROWS + r) * RW
                                   + (g % `PIX_GRPS_X) * `PIX_GRP_COLS + c;
                assign grp_req[g][r*`PIX_GRP_COLS + c] = pix_req_i[P];
                assign pix_gnt_o[P] = grp_gnt[g][r*`PIX_GRP_COLS + c];
            end
        end

        assign grp_en[g] = act_valid_q & (act_q == grp_sel_t'(g)) & run_i
                           & ~fifo_full_i & ~grp_rel[g];  // Off on the release cycle

        pixel_level_1 i_l1 (
            .clk_i         (clk_i),
            .reset_i       (reset_i),
            .enable_i      (grp_en[g]),
            .req_i         (grp_req[g]),
            .gnt_o         (grp_gnt[g]),
            .x_add_o       (x_add[g]),
            .y_add_o       (y_add[g]),
            .gnt_valid_o   (grp_valid[g]),
            .grp_req_o     (grp_any[g]),
            .grp_release_o (grp_rel[g])
        );
    end

    // Next requesting group after the active one with itself last
    always_comb
    begin
        nxt       = act_q;
        nxt_found = 1'b0;
        for (int k = NG; k >= 1; k--)
        begin
            if (grp_any[grp_sel_t'(int'(act_q) + k)])
            begin
                nxt       = grp_sel_t'(int'(act_q) + k);
                nxt_found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            act_q       <= grp_sel_t'(NG - 1);           // Group 0 goes first
            act_valid_q <= 1'b0;
        end
        else if (!act_valid_q || grp_rel[act_q])
        begin
            act_valid_q <= nxt_found;
            act_q       <= nxt;
        end
    end

    assign evt_push_o = |grp_valid;                      // Same cycle as the grant
    assign evt_o.row  = pix_addr_t'((int'(act_q) / `PIX_GRPS_X) * `PIX_GRP_ROWS)
                        + pix_addr_t'(x_add[act_q]);
    assign evt_o.col  = pix_addr_t'((int'(act_q) % `PIX_GRPS_X) * `PIX_GRP_COLS)
                        + pix_addr_t'(y_add[act_q]);

    a_no_push_full: assert property (@(posedge clk_i) disable iff (reset_i)
                                     fifo_full_i |-> !evt_push_o);
    a_push_gnt:     assert property (@(posedge clk_i) disable iff (reset_i)
                                     evt_push_o == (|pix_gnt_o));

endmodule

/* rtl/pixel_readout_top.sv */
// Readout top for the 8x8 array; single Wishbone master, no interrupt
`timescale 1ns/1ps

module pixel_readout_top (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic [63:0]               pix_req_i,     // Index row*8+col
    input  pixel_arb_pkg::wb_req_t    wb_i,
    output logic [63:0]               pix_gnt_o,
    output pixel_arb_pkg::wb_rsp_t    wb_o
);
    import pixel_arb_pkg::*;

    pix_event_t push_evt, head_evt;
    fifo_cnt_t  count;
    logic       push, pop, empty, full, run;

    pixel_level_2 i_l2 (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .run_i       (run),
        .fifo_full_i (full),
        .pix_req_i   (pix_req_i),
        .pix_gnt_o   (pix_gnt_o),
        .evt_push_o  (push),
        .evt_o       (push_evt)
    );

    event_fifo i_fifo (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .push_i  (push),
        .evt_i   (push_evt),
        .pop_i   (pop),
        .evt_o   (head_evt),
        .count_o (count),
        .empty_o (empty),
        .full_o  (full)
    );

    readout_wb_slave i_wb (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .wb_i    (wb_i),
        .evt_i   (head_evt),
        .count_i (count),
        .empty_i (empty),
        .full_i  (full),
        .wb_o    (wb_o),
        .pop_o   (pop),
        .run_o   (run)
    );

endmodule

/* rtl/readout_wb_slave.sv */
// Wishbone classic slave, one ack per strobe; only address bits 3:2 are decoded
`timescale 1ns/1ps

module readout_wb_slave (
    input  logic                         clk_i,
    input  logic                         reset_i,
    input  pixel_arb_pkg::wb_req_t       wb_i,
    input  pixel_arb_pkg::pix_event_t    evt_i,       // FIFO head
    input  pixel_arb_pkg::fifo_cnt_t     count_i,
    input  logic                         empty_i,
    input  logic                         full_i,
    output pixel_arb_pkg::wb_rsp_t       wb_o,
    output logic                         pop_o,       // One pop per EVENT read
    output logic                         run_o        // CONTROL bit 0
);
    import pixel_arb_pkg::*;

    logic        ack_q, done_q;                      // Done blocks a second ack
    logic [31:0] rdat_q, rdat;
    logic        take;

    assign take  = wb_i.cyc & wb_i.stb & ~ack_q & ~done_q;
    assign pop_o = take & ~wb_i.we & (wb_i.adr[3:2] == 2'd0) & ~empty_i;

    always_comb
    begin
        case (wb_i.adr[3:2])
            2'd0:    rdat = {~empty_i, 25'd0, evt_i.row, evt_i.col};  // Zero when empty
            2'd1:    rdat = {26'd0, full_i, empty_i, count_i};
            2'd2:    rdat = {31'd0, run_o};
            default: rdat = '0;
        endcase
        if (empty_i && wb_i.adr[3:2] == 2'd0)
            rdat = '0;
    end

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            ack_q  <= 1'b0;
            done_q <= 1'b0;
            run_o  <= 1'b0;
        end
        else
        begin
            ack_q  <= take;                          // One cycle after strobe
            done_q <= wb_i.cyc & wb_i.stb & (done_q | ack_q);
            if (take && wb_i.we && wb_i.adr[3:2] == 2'd2)
                run_o <= wb_i.dat[0];
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (take)
            rdat_q <= rdat;                          // Captured with the pop
    end

    assign wb_o.ack = ack_q;
    assign wb_o.dat = rdat_q;

endmodule

/* rtl/row_arbiter.sv */
// Round-robin row pick above a pointer; refresh wins over enable and restarts at row 0
`timescale 1ns/1ps
`include "pixel_arb_settings.svh"

module row_arbiter (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          enable_i,     // Select a row this cycle
    input  logic                          refresh_i,    // New pass from row 0
    input  logic [`PIX_GRP_ROWS-1:0]      req_i,        // One bit per row
    output logic [`PIX_GRP_ROWS-1:0]      gnt_o,        // Chosen row, one-hot
    output pixel_arb_pkg::grp_addr_t      xadd_o,       // Chosen row address
    output logic                          pass_done_o   // Nothing left above pointer
);
    import pixel_arb_pkg::*;

    logic [$clog2(`PIX_GRP_ROWS):0] ptr_q;              // Next row to consider, may reach N
    grp_addr_t                      sel;
    logic                           found;

    // Lowest requesting row at or above the pointer
    always_comb
    begin
        sel   = '0;
        found = 1'b0;
        for (int i = `PIX_GRP_ROWS - 1; i >= 0; i--)
        begin
            if (req_i[i] && (i >= int'(ptr_q)))
            begin
                sel   = grp_addr_t'(i);
                found = 1'b1;
            end
        end
    end

    assign pass_done_o = !found;                        // Pass exhausted

    always_ff @(posedge clk_i or posedge reset_i)
    begin
        if (reset_i)
        begin
            ptr_q  <= '0;
            gnt_o  <= '0;
            xadd_o <= '0;
        end
        else if (refresh_i)
        begin
            ptr_q <= '0;                                // Back to row 0
            gnt_o <= '0;
        end
        else if (enable_i)
        begin
            if (found)
            begin
                gnt_o  <= `PIX_GRP_ROWS'(1) << sel;     // Latch the row
                xadd_o <= sel;
                ptr_q  <= {1'b0, sel} + 1'b1;           // Skip past it
            end
            else
                gnt_o <= '0;
        end
    end

endmodule

/* vlog.f */
+incdir+rtl
rtl/pixel_arb_pkg.sv
rtl/row_arbiter.sv
rtl/column_arbiter.sv
rtl/pixel_level_1.sv
rtl/pixel_level_2.sv
rtl/event_fifo.sv
rtl/readout_wb_slave.sv
rtl/pixel_readout_top.sv
dv/pixel_readout_tb.sv
